// ==== audio_cfg_regs.sv ====
// audio configuration register
// holds the stereo select and DMA sound enable for the mixer; written
// through a four-phase req/ack handshake

`default_nettype none

module audio_cfg_regs
	import cfg_pkg::*;
(
	input  logic       clk_32,
	input  logic       xsint,
	input  logic       cfg_wr_req,
	input  audio_cfg_t cfg_wr_data,
	output logic       cfg_wr_ack,
	output audio_cfg_t cfg
);

	hs_state_t state;
	hs_state_t state_nxt;
	logic      load;  // word captured on this edge

	// handshake FSM
	always_comb begin
		state_nxt = state;
		load      = 1'b0;
		case (state)
			hs_idle: begin
				if (cfg_wr_req) begin
					state_nxt = hs_ack;
					load      = 1'b1;  // data is stable while req is high
				end
			end
			hs_ack: begin
				// writer dropped req, release ack
				if (!cfg_wr_req)
					state_nxt = hs_idle;
			end
			default: state_nxt = hs_idle;
		endcase
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			state <= hs_idle;
			cfg   <= CFG_RESET;
		end else begin
			state <= state_nxt;
			if (load)
				cfg <= cfg_wr_data;
		end
	end

	// ack follows the state, so it rises on the capture edge
	assign cfg_wr_ack = (state == hs_ack);

endmodule

`default_nettype wire

// ==== audio_mix.sv ====
// audio mixer
// sums the generator channels mono or stereo, removes the offsets, scales
// generator and DMA sound to 15 bits and adds them per side; two stages

`default_nettype none

module audio_mix
	import audio_pkg::*;
	import cfg_pkg::*;
(
	input  logic          clk_32,
	input  logic          xsint,
	input  audio_cfg_t    cfg,
	input  psg_channels_t psg_ch,
	input  dma_stereo_t   dma_snd,
	output mix_stereo_t   mix
);

	psg_sum_t    ch_a, ch_b, ch_c;      // channels widened to the sum width
	psg_sum_t    sum_mono;
	psg_sum_t    sum_l, sum_r;
	psg_sum_t    psg_s_l, psg_s_r;      // signed generator sums of stage 1
	dma_sample_t dma_s_l, dma_s_r;      // signed and gated DMA of stage 1
	mix_sample_t psg_term_l, psg_term_r;
	mix_sample_t dma_term_l, dma_term_r;

	// s times 32 with the low bits filled from the top four bits of s
	function automatic mix_sample_t psg_scale(input psg_sum_t s);
		psg_scale = {s, 1'b0, s[PSG_SUM_W-1 -: 4]};
	endfunction

	// d times 128 with the low bits filled from the top six bits of d
	function automatic mix_sample_t dma_scale(input dma_sample_t d);
		dma_scale = {d, 1'b0, d[DMA_W-1 -: 6]};
	endfunction

	assign ch_a = {2'b00, psg_ch.a};
	assign ch_b = {2'b00, psg_ch.b};
	assign ch_c = {2'b00, psg_ch.c};

	assign sum_mono = ch_a + ch_b + ch_c;

	// stereo puts a left, c right and b in the middle
	assign sum_l = cfg.psg_stereo ? ch_a + ch_b : sum_mono;
	assign sum_r = cfg.psg_stereo ? ch_c + ch_b : sum_mono;

	// stage 1 removes the offsets and gates DMA sound
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			psg_s_l <= '0;
			psg_s_r <= '0;
			dma_s_l <= '0;
			dma_s_r <= '0;
		end else begin
			psg_s_l <= sum_l - PSG_OFFSET;
			psg_s_r <= sum_r - PSG_OFFSET;
			dma_s_l <= cfg.dma_snd_en ? dma_snd.left - DMA_OFFSET : '0;  // zero scales to zero
			dma_s_r <= cfg.dma_snd_en ? dma_snd.right - DMA_OFFSET : '0;
		end
	end

	assign psg_term_l = psg_scale(psg_s_l);
	assign psg_term_r = psg_scale(psg_s_r);
	assign dma_term_l = dma_scale(dma_s_l);
	assign dma_term_r = dma_scale(dma_s_r);

	// stage 2 adds the terms with a 15 bit wrap per side
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix <= '0;
		end else begin
			mix.left  <= psg_term_l + dma_term_l;
			mix.right <= psg_term_r + dma_term_r;
		end
	end

endmodule

`default_nettype wire

// ==== audio_pkg.sv ====
// audio sample package
// widths, sample types and channel structs of the sound path, plus the
// offsets used by the mixer to turn unsigned levels into signed samples

`default_nettype none

package audio_pkg;

	// widths fixed by the sound hardware
	localparam int PSG_W     = 8;   // one generator channel
	localparam int DMA_W     = 8;   // one DMA sound channel
	localparam int PSG_SUM_W = 10;  // three generator channels summed
	localparam int MIX_W     = 15;  // mixed sample into the DAC

	typedef logic [PSG_W-1:0]     psg_sample_t;
	typedef logic [DMA_W-1:0]     dma_sample_t;
	typedef logic [PSG_SUM_W-1:0] psg_sum_t;     // signed once offset removed
	typedef logic [MIX_W-1:0]     mix_sample_t;  // two's complement

	// midpoint of a three channel sum
	localparam psg_sum_t    PSG_OFFSET = 10'd512;
	// midpoint of an unsigned DMA sample
	localparam dma_sample_t DMA_OFFSET = 8'd128;

	typedef struct packed {
		psg_sample_t a;
		psg_sample_t b;
		psg_sample_t c;
	} psg_channels_t;

	typedef struct packed {
		dma_sample_t left;
		dma_sample_t right;
	} dma_stereo_t;

	typedef struct packed {
		mix_sample_t left;
		mix_sample_t right;
	} mix_stereo_t;

endpackage

`default_nettype wire

// ==== audio_top.sv ====
// audio output path top level
// configuration register, two-stage mixer and stereo sigma-delta DAC;
// sample inputs to settled bitstream in three cycles

`default_nettype none

module audio_top
	import audio_pkg::*;
	import cfg_pkg::*;
(
	input  logic          clk_32,
	input  logic          xsint,
	input  logic          cfg_wr_req,
	input  audio_cfg_t    cfg_wr_data,
	output logic          cfg_wr_ack,
	input  psg_channels_t psg_ch,
	input  dma_stereo_t   dma_snd,
	output logic          audio_l,
	output logic          audio_r
);

	audio_cfg_t  cfg;  // stereo select and DMA enable
	mix_stereo_t mix;  // 15 bit per side, into the DAC

	audio_cfg_regs audio_cfg_regs_inst (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.cfg_wr_req  (cfg_wr_req),
		.cfg_wr_data (cfg_wr_data),
		.cfg_wr_ack  (cfg_wr_ack),
		.cfg         (cfg)
	);

	// two register stages
	audio_mix audio_mix_inst (
		.clk_32  (clk_32),
		.xsint   (xsint),
		.cfg     (cfg),
		.psg_ch  (psg_ch),
		.dma_snd (dma_snd),
		.mix     (mix)
	);

	// one register stage
	sigma_delta_dac sigma_delta_dac_inst (
		.clk_32  (clk_32),
		.xsint   (xsint),
		.mix     (mix),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

`default_nettype wire

// ==== audio_top_asserts.sv ====
// audio path assertions
// four-phase handshake order, configuration load timing and known outputs,
// bound into the audio top level

`default_nettype none

module audio_top_asserts
	import cfg_pkg::*;
(
	input logic       clk_32,
	input logic       xsint,
	input logic       cfg_wr_req,
	input logic       cfg_wr_ack,
	input audio_cfg_t cfg,
	input logic       audio_l,
	input logic       audio_r
);

	timeunit 1ns;
	timeprecision 1ps;

	// ack rises on an edge that saw req high
	ack_rise_on_req: assert property (@(posedge clk_32) disable iff (!xsint)
		$rose(cfg_wr_ack) |-> $past(cfg_wr_req))
		else $error("cfg_wr_ack rose without cfg_wr_req");

	ack_fall_on_release: assert property (@(posedge clk_32) disable iff (!xsint)
		$fell(cfg_wr_ack) |-> !$past(cfg_wr_req))
		else $error("cfg_wr_ack fell while cfg_wr_req was high");

	// word is loaded only together with ack
	cfg_load_with_ack: assert property (@(posedge clk_32) disable iff (!xsint)
		!$stable(cfg) |-> $rose(cfg_wr_ack))
		else $error("cfg changed outside a write");

	outputs_known: assert property (@(posedge clk_32) disable iff (!xsint)
		!$isunknown({audio_l, audio_r, cfg_wr_ack}))
		else $error("unknown value on an audio_top output");

endmodule

`default_nettype wire

// ==== cfg_pkg.sv ====
// audio configuration package
// the configuration word that steers the mixer and the states of
// the four-phase write handshake that loads it

`default_nettype none

package cfg_pkg;

	typedef struct packed {
		logic psg_stereo;  // 1 = a left, c right, b on both
		logic dma_snd_en;  // 0 = DMA sound muted
	} audio_cfg_t;

	// mono, DMA sound muted
	localparam audio_cfg_t CFG_RESET = '{psg_stereo: 1'b0, dma_snd_en: 1'b0};

	// write handshake
	typedef enum logic {
		hs_idle = 1'b0,  // waiting for req
		hs_ack  = 1'b1   // word taken, waiting for req to drop
	} hs_state_t;

endpackage

`default_nettype wire

// ==== files.f ====
audio_pkg.sv
cfg_pkg.sv
audio_cfg_regs.sv
audio_mix.sv
sigma_delta_dac.sv
audio_top.sv
audio_top_asserts.sv
tb_audio_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the audio path testbench with Verilator and run it.
# The exit status is the simulator's: non-zero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_audio_top \
	-f files.f \
	-o tb_audio_top
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_audio_top
status=$?
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit $status
fi

exit 0

// ==== sigma_delta_dac.sv ====
// stereo sigma-delta DAC
// first-order modulator per side; the offset-binary mix is added into an
// accumulator every cycle and the carry is the output bit

`default_nettype none

module sigma_delta_dac
	import audio_pkg::*;
(
	input  logic        clk_32,
	input  logic        xsint,
	input  mix_stereo_t mix,
	output logic        audio_l,
	output logic        audio_r
);

	mix_sample_t      side_in  [2];  // 0 left, 1 right
	mix_sample_t      side_ob  [2];  // offset binary
	logic [MIX_W-1:0] acc      [2];
	logic [MIX_W:0]   acc_sum  [2];  // carry in the top bit
	logic             bit_out  [2];

	assign side_in[0] = mix.left;
	assign side_in[1] = mix.right;

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			// flipped sign bit maps -16384..16383 onto 0..32767
			side_ob[i] = {~side_in[i][MIX_W-1], side_in[i][MIX_W-2:0]};
			acc_sum[i] = {1'b0, acc[i]} + {1'b0, side_ob[i]};
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			for (int i = 0; i < 2; i++) begin
				acc[i]     <= '0;
				bit_out[i] <= 1'b0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				acc[i]     <= acc_sum[i][MIX_W-1:0];
				bit_out[i] <= acc_sum[i][MIX_W];  // one per wrap of the accumulator
			end
		end
	end

	assign audio_l = bit_out[0];
	assign audio_r = bit_out[1];

endmodule

`default_nettype wire

// ==== tb_audio_top.sv ====
// testbench for the audio output path
// writes the configuration over the four-phase port, applies sample levels
// from a table and counts ones on each bitstream against the mixing rule

`default_nettype none

module tb_audio_top
	import audio_pkg::*;
	import cfg_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          CLK_HALF    = 20;
	localparam int          WINDOW      = 32768;  // one full accumulator cycle
	localparam int          HS_LIMIT    = 8;      // cycles allowed per ack edge
	localparam int          FIXED_ROWS  = 10;
	localparam int          RAND_ROWS   = 6;
	localparam int          NUM_ROWS    = FIXED_ROWS + RAND_ROWS;
	// one extra window for the check made straight after reset
	localparam int          WDOG_CYCLES = (NUM_ROWS + 1) * 33000 + 1000;
	localparam logic [31:0] RAND_SEED   = 32'h5b01_740b;

	localparam audio_cfg_t CFG_MONO       = '{psg_stereo: 1'b0, dma_snd_en: 1'b0};
	localparam audio_cfg_t CFG_MONO_DMA   = '{psg_stereo: 1'b0, dma_snd_en: 1'b1};
	localparam audio_cfg_t CFG_STEREO     = '{psg_stereo: 1'b1, dma_snd_en: 1'b0};
	localparam audio_cfg_t CFG_STEREO_DMA = '{psg_stereo: 1'b1, dma_snd_en: 1'b1};

	typedef struct packed {
		audio_cfg_t    cfg;
		psg_channels_t psg;
		dma_stereo_t   dma;
		int            exp_l;  // ones per window
		int            exp_r;
	} row_t;

	logic          clk_32;
	logic          xsint;
	logic          cfg_wr_req;
	audio_cfg_t    cfg_wr_data;
	logic          cfg_wr_ack;
	psg_channels_t psg_ch;
	dma_stereo_t   dma_snd;
	logic          audio_l;
	logic          audio_r;

	row_t rows[$];

	audio_top audio_top_inst (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.cfg_wr_req  (cfg_wr_req),
		.cfg_wr_data (cfg_wr_data),
		.cfg_wr_ack  (cfg_wr_ack),
		.psg_ch      (psg_ch),
		.dma_snd     (dma_snd),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	bind audio_top audio_top_asserts audio_top_asserts_inst (
		.clk_32     (clk_32),
		.xsint      (xsint),
		.cfg_wr_req (cfg_wr_req),
		.cfg_wr_ack (cfg_wr_ack),
		.cfg        (cfg),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

	initial begin
		clk_32 = 1'b0;
		forever #CLK_HALF clk_32 = ~clk_32;
	end

	initial begin
		repeat (WDOG_CYCLES) @(posedge clk_32);
		fail_run("watchdog expired, the tests did not finish in time");
	end

	// expected ones count of one side from the mixing and DAC arithmetic
	function automatic int expected_count(input audio_cfg_t c, input psg_channels_t p,
			input dma_sample_t d, input bit right_side);
		int a, b, cc, sum, s, g, dd, dt, m;
		a  = int'(p.a);
		b  = int'(p.b);
		cc = int'(p.c);
		if (!c.psg_stereo)
			sum = a + b + cc;
		else if (right_side)
			sum = cc + b;
		else
			sum = a + b;
		s  = sum - 512;
		g  = s * 32 + ((s & 32'h3ff) >> 6);  // top four of ten bits
		dd = int'(d) - 128;
		dt = c.dma_snd_en ? dd * 128 + ((dd & 32'hff) >> 2) : 0;
		m  = (g + dt) & 32'h7fff;  // 15 bit wrap
		if (m >= 16384)
			m = m - 32768;
		return m + 16384;
	endfunction

	task automatic abort_run();
		$display("sim failed");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic fail_run(input string reason);
		$display("%s", reason);
		abort_run();
	endtask

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual != expected) begin
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, name, actual,
				expected);
			abort_run();
		end
	endtask

	task automatic add_row(input audio_cfg_t c, input psg_channels_t p, input dma_stereo_t d);
		row_t r;
		r.cfg   = c;
		r.psg   = p;
		r.dma   = d;
		r.exp_l = expected_count(c, p, d.left, 1'b0);
		r.exp_r = expected_count(c, p, d.right, 1'b1);
		rows.push_back(r);
	endtask

	// four-phase write with each ack edge timed in cycles
	task automatic write_cfg(input audio_cfg_t w);
		int n;
		@(negedge clk_32);
		cfg_wr_data = w;
		cfg_wr_req  = 1'b1;
		n = 0;
		do begin
			@(negedge clk_32);
			n++;
		end while (!cfg_wr_ack && n < HS_LIMIT);
		if (!cfg_wr_ack)
			fail_run("cfg_wr_ack never rose after cfg_wr_req was raised");
		check_value("cfg_wr_ack rise latency", n, 1);
		cfg_wr_req = 1'b0;
		n = 0;
		do begin
			@(negedge clk_32);
			n++;
		end while (cfg_wr_ack && n < HS_LIMIT);
		if (cfg_wr_ack)
			fail_run("cfg_wr_ack never fell after cfg_wr_req was dropped");
		check_value("cfg_wr_ack fall latency", n, 1);
	endtask

	// apply levels, let three stages settle, count one full window
	task automatic measure(input psg_channels_t p, input dma_stereo_t d,
			output int ones_l, output int ones_r);
		@(negedge clk_32);
		psg_ch  = p;
		dma_snd = d;
		repeat (3) @(posedge clk_32);
		ones_l = 0;
		ones_r = 0;
		for (int i = 0; i < WINDOW; i++) begin
			@(negedge clk_32);
			if (audio_l)
				ones_l++;
			if (audio_r)
				ones_r++;
		end
	endtask

	initial begin
		logic [31:0] rnd_a;
		logic [31:0] rnd_b;
		int          ones_l;
		int          ones_r;
		row_t        row;

		void'($urandom(RAND_SEED));

		xsint       = 1'b0;
		cfg_wr_req  = 1'b0;
		cfg_wr_data = CFG_RESET;
		psg_ch      = '0;
		dma_snd     = '0;

		add_row(CFG_MONO,       {8'd10,  8'd200, 8'd90},  {8'd128, 8'd128});
		add_row(CFG_MONO,       {8'd255, 8'd0,   8'd40},  {8'd60,  8'd220});
		add_row(CFG_MONO_DMA,   {8'd100, 8'd100, 8'd100}, {8'd200, 8'd30});
		add_row(CFG_STEREO,     {8'd200, 8'd100, 8'd20},  {8'd128, 8'd128});
		add_row(CFG_STEREO,     {8'd0,   8'd255, 8'd255}, {8'd128, 8'd128});
		add_row(CFG_STEREO_DMA, {8'd50,  8'd60,  8'd70},  {8'd200, 8'd30});
		add_row(CFG_STEREO,     {8'd50,  8'd60,  8'd70},  {8'd200, 8'd30});
		add_row(CFG_MONO,       {8'd255, 8'd255, 8'd255}, {8'd255, 8'd255});  // full scale
		add_row(CFG_MONO,       {8'd0,   8'd0,   8'd0},   {8'd0,   8'd0});    // all zero
		add_row(CFG_MONO_DMA,   {8'd171, 8'd171, 8'd170}, {8'd255, 8'd0});    // DMA extremes
		for (int k = 0; k < RAND_ROWS; k++) begin
			rnd_a = $urandom();
			rnd_b = $urandom();
			add_row(rnd_a[25:24], rnd_a[23:0], rnd_b[15:0]);
		end

		repeat (2) @(negedge clk_32);
		xsint = 1'b1;

		// no write yet, generator at midpoint, DMA muted by reset value
		check_value("cfg_wr_ack after reset", int'(cfg_wr_ack), 0);
		measure({8'd171, 8'd171, 8'd170}, {8'd200, 8'd40}, ones_l, ones_r);
		check_value("audio_l ones after reset", ones_l, 16384);
		check_value("audio_r ones after reset", ones_r, 16384);

		foreach (rows[k]) begin
			row = rows[k];
			write_cfg(row.cfg);
			measure(row.psg, row.dma, ones_l, ones_r);
			check_value($sformatf("audio_l ones, row %0d", k), ones_l, row.exp_l);
			check_value($sformatf("audio_r ones, row %0d", k), ones_r, row.exp_r);
		end

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
